/* hdl/sgd_pkg.sv */
////////////////////////////////////////////////////////////
// sgd engine shared types
// lane and model word layout, run configuration,
// write-back command and the run state encoding
////////////////////////////////////////////////////////////

package sgd_pkg;

	////////////////////////////////////////////////////////////
	// sizes
	////////////////////////////////////////////////////////////

	// 512-bit host bus carries 16 lanes
	localparam int unsigned LANES = 16;
	localparam int unsigned LANE_W = 32;

	// config field widths
	localparam int unsigned DIM_W = 16;
	localparam int unsigned EPOCH_W = 16;
	localparam int unsigned SHIFT_W = 5;

	// one model word on the host side
	localparam int unsigned BYTES_PER_WORD = 64;

	////////////////////////////////////////////////////////////
	// data types
	////////////////////////////////////////////////////////////

	// one signed model lane
	typedef logic signed [LANE_W-1:0] lane_t;

	// full model word, also a gradient beat and a write-back beat
	typedef lane_t [LANES-1:0] x_word_t;

	// run configuration, latched on start
	typedef struct packed {
		logic [63:0]        addr_model;
		logic [DIM_W-1:0]   dimension;
		logic [EPOCH_W-1:0] number_of_epochs;
		logic [SHIFT_W-1:0] step_shift;
	} sgd_cfg_t;

	// host write command, length in bytes
	typedef struct packed {
		logic [63:0] addr;
		logic [31:0] length;
	} wb_cmd_t;

	// run states
	typedef enum logic [2:0] {
		IDLE,
		CLEAR,
		UPDATE,
		WRITEBACK,
		DONE
	} sgd_state_e;

endpackage

/* hdl/sgd_ctrl_fsm.sv */
////////////////////////////////////////////////////////////
// sgd run control
// run FSM, config latch, counter and datapath strobes,
// done level and run cycle count
////////////////////////////////////////////////////////////

module sgd_ctrl_fsm #(
	parameter int X_ADDR_BITS = 10
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start,
	input  sgd_pkg::sgd_cfg_t cfg,
	input  logic              grad_valid,
	input  logic              rd_issue,
	input  logic              last_word,
	input  logic              last_epoch,
	input  logic              wb_done,
	output sgd_pkg::sgd_cfg_t cfg_q,
	output logic              step,
	output logic              restart,
	output logic              clear_wr,
	output logic              upd_go,
	output logic              wb_active,
	output logic              grad_ready,
	output logic              um_done,
	output logic [31:0]       run_cycles
);
	import sgd_pkg::*;

	localparam int unsigned DEPTH = 1 << X_ADDR_BITS;

	sgd_state_e state;
	sgd_state_e next_state;
	logic       start_go;

	// start only counts while the engine is parked
	assign start_go = start && (state == IDLE || state == DONE);

	always_comb begin
		next_state = state;
		case (state)
			IDLE:      if (start_go) next_state = CLEAR;
			// one clear write per cycle, leave after the last word
			CLEAR:     if (last_word) next_state = UPDATE;
			UPDATE:    if (grad_valid && last_word && last_epoch) next_state = WRITEBACK;
			WRITEBACK: if (wb_done) next_state = DONE;
			DONE:      if (start_go) next_state = CLEAR;
			default:   next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	// config copy for the whole run
	always_ff @(posedge clk) begin
		if (start_go) begin
			cfg_q <= cfg;
		end
	end

	// counter steps per state
	always_comb begin
		case (state)
			CLEAR:     step = 1'b1;
			UPDATE:    step = grad_valid;
			WRITEBACK: step = rd_issue;
			default:   step = 1'b0;
		endcase
	end

	// zero the counters on the edge that enters a counting state
	assign restart = (next_state != state) &&
		(next_state == CLEAR || next_state == UPDATE || next_state == WRITEBACK);

	assign clear_wr   = (state == CLEAR);
	assign upd_go     = (state == UPDATE) && grad_valid;
	assign wb_active  = (state == WRITEBACK);
	assign grad_ready = (state == UPDATE);
	assign um_done    = (state == DONE);

	// run length, frozen once DONE is reached
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			run_cycles <= '0;
		end else if (start_go) begin
			run_cycles <= '0;
		end else if (state != IDLE && state != DONE) begin
			run_cycles <= run_cycles + 32'd1;
		end
	end

	// latched dimension must fit the store and keep the update pipe hazard free
	a_dim_range: assert property (@(posedge clk) disable iff (!rst_n)
		start_go |=> (cfg_q.dimension >= 2) && (cfg_q.dimension <= DEPTH))
		else $error("dimension %0d out of range", cfg_q.dimension);

endmodule

/* hdl/sgd_word_counter.sv */
////////////////////////////////////////////////////////////
// model word index and epoch counter
// single source of model addresses for every phase
////////////////////////////////////////////////////////////

module sgd_word_counter #(
	parameter int X_ADDR_BITS = 10
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         step,
	input  logic                         restart,
	input  logic [sgd_pkg::DIM_W-1:0]    dimension,
	input  logic [sgd_pkg::EPOCH_W-1:0]  number_of_epochs,
	output logic [X_ADDR_BITS-1:0]       word_idx,
	output logic                         last_word,
	output logic                         last_epoch
);
	import sgd_pkg::*;

	logic [EPOCH_W-1:0] epoch_cnt;
	logic [DIM_W-1:0]   word_ext;

	// index seen at config width
	assign word_ext = DIM_W'(word_idx);

	assign last_word  = (word_ext == dimension - DIM_W'(1));
	assign last_epoch = (epoch_cnt == number_of_epochs - EPOCH_W'(1));

	always_ff @(posedge clk) begin
		if (!rst_n || restart) begin
			word_idx  <= '0;
			epoch_cnt <= '0;
		end else if (step) begin
			if (last_word) begin
				// wrap, next pass over the model
				word_idx  <= '0;
				epoch_cnt <= epoch_cnt + EPOCH_W'(1);
			end else begin
				word_idx <= word_idx + X_ADDR_BITS'(1);
			end
		end
	end

	// a step never leaves the index outside the model
	a_idx_bound: assert property (@(posedge clk) disable iff (!rst_n)
		step |=> word_ext < dimension)
		else $error("word_idx %0d past dimension %0d", word_idx, dimension);

endmodule

/* hdl/sgd_model_ram.sv */
////////////////////////////////////////////////////////////
// model store
// simple dual-port block RAM, registered read
////////////////////////////////////////////////////////////

module sgd_model_ram #(
	parameter int X_ADDR_BITS = 10
) (
	input  logic                   clk,
	input  logic                   wr_en,
	input  logic [X_ADDR_BITS-1:0] wr_addr,
	input  sgd_pkg::x_word_t       wr_data,
	input  logic [X_ADDR_BITS-1:0] rd_addr,
	output sgd_pkg::x_word_t       rd_data
);
	import sgd_pkg::*;

	localparam int unsigned DEPTH = 1 << X_ADDR_BITS;

	x_word_t mem [0:DEPTH-1];

	// read and write on one edge, same address reads the old word
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		rd_data <= mem[rd_addr];
	end

endmodule

/* hdl/sgd_x_update.sv */
////////////////////////////////////////////////////////////
// model update datapath
// clear writes, then per lane x = x - (g >>> step_shift)
// as a read-modify-write around the model store
////////////////////////////////////////////////////////////

module sgd_x_update #(
	parameter int X_ADDR_BITS = 10
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          clear_wr,
	input  logic                          upd_go,
	input  logic [X_ADDR_BITS-1:0]        word_idx,
	input  sgd_pkg::x_word_t              grad,
	input  logic [sgd_pkg::SHIFT_W-1:0]   step_shift,
	input  sgd_pkg::x_word_t              rd_data,
	output logic                          wr_en,
	output logic [X_ADDR_BITS-1:0]        wr_addr,
	output sgd_pkg::x_word_t              wr_data
);
	import sgd_pkg::*;

	////////////////////////////////////////////////////////////
	// beat stage
	////////////////////////////////////////////////////////////

	logic                   s1_valid;
	logic [X_ADDR_BITS-1:0] s1_addr;
	x_word_t                s1_grad;
	x_word_t                upd_word;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= upd_go;
		end
	end

	// beat captured on the same edge the store reads word_idx
	always_ff @(posedge clk) begin
		if (upd_go) begin
			s1_addr <= word_idx;
			s1_grad <= grad;
		end
	end

	////////////////////////////////////////////////////////////
	// lane arithmetic
	////////////////////////////////////////////////////////////

	// arithmetic shift keeps the gradient sign
	for (genvar i = 0; i < LANES; i++) begin : g_lane
		assign upd_word[i] = rd_data[i] - (s1_grad[i] >>> step_shift);
	end

	// write lands one edge after the beat, before the next read of that word
	assign wr_en   = s1_valid || clear_wr;
	assign wr_addr = s1_valid ? s1_addr : word_idx;
	assign wr_data = s1_valid ? upd_word : '0;

	// clear and update never share the write port
	a_port_excl: assert property (@(posedge clk) disable iff (!rst_n)
		clear_wr |-> !upd_go && !s1_valid)
		else $error("clear write overlaps a model update");

	// back to back beats never hit the word still being written
	a_no_raw: assert property (@(posedge clk) disable iff (!rst_n)
		upd_go && s1_valid |-> word_idx != s1_addr)
		else $error("read of word %0h while its update is pending", word_idx);

endmodule

/* hdl/sgd_x_writeback.sv */
////////////////////////////////////////////////////////////
// model write-back
// host command, paced reads of the store and the
// registered 512-bit data beats
////////////////////////////////////////////////////////////

module sgd_x_writeback #(
	parameter int X_ADDR_BITS = 10
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       wb_active,
	input  logic [63:0]                addr_model,
	input  logic [sgd_pkg::DIM_W-1:0]  dimension,
	input  logic                       last_word,
	input  sgd_pkg::x_word_t           rd_data,
	input  logic                       x_data_out_almost_full,
	output logic                       rd_issue,
	output logic                       send_back_start,
	output sgd_pkg::wb_cmd_t           send_back,
	output sgd_pkg::x_word_t           x_data_out,
	output logic                       x_data_out_valid,
	output logic                       wb_done
);
	import sgd_pkg::*;

	// words the store can hold
	localparam int unsigned DEPTH = 1 << X_ADDR_BITS;

	logic cmd_sent;
	logic rd_done;
	logic rd_v1;
	logic rd_last1;

	////////////////////////////////////////////////////////////
	// command
	////////////////////////////////////////////////////////////

	// first write-back cycle only
	assign send_back_start  = wb_active && !cmd_sent;
	assign send_back.addr   = addr_model;
	assign send_back.length = 32'(dimension) * BYTES_PER_WORD;

	// one read per cycle after the command while almost-full is low
	assign rd_issue = wb_active && cmd_sent && !rd_done && !x_data_out_almost_full;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cmd_sent         <= 1'b0;
			rd_done          <= 1'b0;
			rd_v1            <= 1'b0;
			rd_last1         <= 1'b0;
			x_data_out_valid <= 1'b0;
			wb_done          <= 1'b0;
		end else begin
			cmd_sent <= wb_active;
			// set by the last read and cleared outside write-back
			if (!wb_active) begin
				rd_done <= 1'b0;
			end else if (rd_issue && last_word) begin
				rd_done <= 1'b1;
			end
			// read data shows up one cycle after issue
			rd_v1    <= rd_issue;
			rd_last1 <= rd_issue && last_word;
			// beat leaves the cycle after
			x_data_out_valid <= rd_v1;
			wb_done          <= rd_last1;
		end
	end

	////////////////////////////////////////////////////////////
	// data beat
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rd_v1) begin
			x_data_out <= rd_data;
		end
	end

	// at most the two beats already in the read pipe follow almost-full
	a_af_drain: assert property (@(posedge clk) disable iff (!rst_n)
		x_data_out_almost_full [*3] |-> !x_data_out_valid)
		else $error("x_data_out_valid three cycles into almost-full");

	// command length never exceeds the store
	a_len_fit: assert property (@(posedge clk) disable iff (!rst_n)
		send_back_start |-> dimension <= DEPTH)
		else $error("write-back of %0d words exceeds the store", dimension);

endmodule

/* hdl/sgd_bw_top.sv */
////////////////////////////////////////////////////////////
// bit-weaving sgd model engine
// control, word counter, model store, update and write-back
////////////////////////////////////////////////////////////

module sgd_bw_top #(
	parameter int X_ADDR_BITS = 10
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start,
	input  sgd_pkg::sgd_cfg_t cfg,
	input  logic              grad_valid,
	input  sgd_pkg::x_word_t  grad,
	input  logic              x_data_out_almost_full,
	output logic              grad_ready,
	output logic              um_done,
	output logic [31:0]       run_cycles,
	output logic              send_back_start,
	output sgd_pkg::wb_cmd_t  send_back,
	output sgd_pkg::x_word_t  x_data_out,
	output logic              x_data_out_valid
);
	import sgd_pkg::*;

	// control strobes
	sgd_cfg_t cfg_q;
	logic     step;
	logic     restart;
	logic     clear_wr;
	logic     upd_go;
	logic     wb_active;
	logic     rd_issue;
	logic     wb_done;

	// counter
	logic [X_ADDR_BITS-1:0] word_idx;
	logic                   last_word;
	logic                   last_epoch;

	// store ports
	x_word_t                rd_data;
	logic                   wr_en;
	logic [X_ADDR_BITS-1:0] wr_addr;
	x_word_t                wr_data;

	sgd_ctrl_fsm #(
		.X_ADDR_BITS (X_ADDR_BITS)
	) u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.cfg        (cfg),
		.grad_valid (grad_valid),
		.rd_issue   (rd_issue),
		.last_word  (last_word),
		.last_epoch (last_epoch),
		.wb_done    (wb_done),
		.cfg_q      (cfg_q),
		.step       (step),
		.restart    (restart),
		.clear_wr   (clear_wr),
		.upd_go     (upd_go),
		.wb_active  (wb_active),
		.grad_ready (grad_ready),
		.um_done    (um_done),
		.run_cycles (run_cycles)
	);

	// shared address for clear, update and write-back
	sgd_word_counter #(
		.X_ADDR_BITS (X_ADDR_BITS)
	) u_counter (
		.clk              (clk),
		.rst_n            (rst_n),
		.step             (step),
		.restart          (restart),
		.dimension        (cfg_q.dimension),
		.number_of_epochs (cfg_q.number_of_epochs),
		.word_idx         (word_idx),
		.last_word        (last_word),
		.last_epoch       (last_epoch)
	);

	sgd_model_ram #(
		.X_ADDR_BITS (X_ADDR_BITS)
	) u_model (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (word_idx),
		.rd_data (rd_data)
	);

	sgd_x_update #(
		.X_ADDR_BITS (X_ADDR_BITS)
	) u_update (
		.clk        (clk),
		.rst_n      (rst_n),
		.clear_wr   (clear_wr),
		.upd_go     (upd_go),
		.word_idx   (word_idx),
		.grad       (grad),
		.step_shift (cfg_q.step_shift),
		.rd_data    (rd_data),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data)
	);

	sgd_x_writeback #(
		.X_ADDR_BITS (X_ADDR_BITS)
	) u_writeback (
		.clk                    (clk),
		.rst_n                  (rst_n),
		.wb_active              (wb_active),
		.addr_model             (cfg_q.addr_model),
		.dimension              (cfg_q.dimension),
		.last_word              (last_word),
		.rd_data                (rd_data),
		.x_data_out_almost_full (x_data_out_almost_full),
		.rd_issue               (rd_issue),
		.send_back_start        (send_back_start),
		.send_back              (send_back),
		.x_data_out             (x_data_out),
		.x_data_out_valid       (x_data_out_valid),
		.wb_done                (wb_done)
	);

endmodule

/* verif/sgd_bw_tb.sv */
////////////////////////////////////////////////////////////
// sgd_bw testbench
// two runs of random gradients with gaps, random almost-full
// during write-back, concurrent checks against a reference model
////////////////////////////////////////////////////////////

module sgd_bw_tb;
	import sgd_pkg::*;

	// small store keeps the runs short, first run fills it
	localparam int X_ADDR_BITS = 4;
	localparam int DEPTH = 1 << X_ADDR_BITS;
	localparam int READY_LIMIT = 200;
	localparam int GRAD_LIMIT = 2000;
	localparam int WB_LIMIT = 4000;

	logic     clk;
	logic     rst_n;
	logic     start;
	sgd_cfg_t cfg;
	logic     grad_valid;
	x_word_t  grad;
	logic     x_data_out_almost_full;
	logic     grad_ready;
	logic     um_done;
	logic [31:0] run_cycles;
	logic     send_back_start;
	wb_cmd_t  send_back;
	x_word_t  x_data_out;
	logic     x_data_out_valid;

	// expected run values and bookkeeping
	x_word_t     ref_mem [0:DEPTH-1];
	x_word_t     exp_beat;
	logic [63:0] exp_addr;
	logic [31:0] exp_len;
	int          exp_dim;
	int          cmd_cnt;
	int          beat_cnt;
	int          errors;
	int          timeouts;
	logic        timed_out;
	integer      seed;

	sgd_bw_top #(
		.X_ADDR_BITS (X_ADDR_BITS)
	) DUT (
		.clk                    (clk),
		.rst_n                  (rst_n),
		.start                  (start),
		.cfg                    (cfg),
		.grad_valid             (grad_valid),
		.grad                   (grad),
		.x_data_out_almost_full (x_data_out_almost_full),
		.grad_ready             (grad_ready),
		.um_done                (um_done),
		.run_cycles             (run_cycles),
		.send_back_start        (send_back_start),
		.send_back              (send_back),
		.x_data_out             (x_data_out),
		.x_data_out_valid       (x_data_out_valid)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// command and beat counts, zeroed by each start
	always @(posedge clk) begin
		if (!rst_n || start) begin
			cmd_cnt  <= 0;
			beat_cnt <= 0;
		end else begin
			if (send_back_start) cmd_cnt <= cmd_cnt + 1;
			if (x_data_out_valid) beat_cnt <= beat_cnt + 1;
		end
	end

	// reference word for the next beat
	assign exp_beat = ref_mem[beat_cnt[X_ADDR_BITS-1:0]];

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	a_reset_lvl: assert property (@(posedge clk) $rose(rst_n) |->
		!grad_ready && !um_done && !send_back_start && !x_data_out_valid && run_cycles == 0)
		else begin
			errors++;
			$display("[ERROR] after reset grad_ready=%h um_done=%h send_back_start=%h valid=%h",
				$sampled(grad_ready), $sampled(um_done), $sampled(send_back_start),
				$sampled(x_data_out_valid));
			$display("[ERROR] after reset run_cycles got %h expected 0", $sampled(run_cycles));
		end

	a_cmd_addr: assert property (@(posedge clk) disable iff (!rst_n)
		send_back_start |-> send_back.addr == exp_addr)
		else begin
			errors++;
			$display("[ERROR] send_back.addr got %h expected %h",
				$sampled(send_back.addr), $sampled(exp_addr));
		end

	a_cmd_len: assert property (@(posedge clk) disable iff (!rst_n)
		send_back_start |-> send_back.length == exp_len)
		else begin
			errors++;
			$display("[ERROR] send_back.length got %h expected %h",
				$sampled(send_back.length), $sampled(exp_len));
		end

	// one command per run
	a_cmd_once: assert property (@(posedge clk) disable iff (!rst_n)
		send_back_start |-> cmd_cnt == 0)
		else begin
			errors++;
			$display("second write-back command in one run");
		end

	// data only after its command
	a_cmd_first: assert property (@(posedge clk) disable iff (!rst_n)
		x_data_out_valid |-> cmd_cnt == 1)
		else begin
			errors++;
			$display("data beat without exactly one preceding write-back command");
		end

	a_beat_data: assert property (@(posedge clk) disable iff (!rst_n)
		x_data_out_valid |-> x_data_out == exp_beat)
		else begin
			errors++;
			$display("[ERROR] x_data_out beat %0h got %h expected %h", $sampled(beat_cnt),
				$sampled(x_data_out), $sampled(exp_beat));
		end

	a_beat_count: assert property (@(posedge clk) disable iff (!rst_n)
		x_data_out_valid |-> beat_cnt < exp_dim)
		else begin
			errors++;
			$display("more data beats than model words");
		end

	// at most two beats already in flight follow almost-full
	a_af_hold: assert property (@(posedge clk) disable iff (!rst_n)
		x_data_out_almost_full [*3] |-> !x_data_out_valid)
		else begin
			errors++;
			$display("data beat three cycles into almost-full");
		end

	a_done_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(um_done) |-> beat_cnt == exp_dim && cmd_cnt == 1)
		else begin
			errors++;
			$display("[ERROR] at um_done rise beats got %h expected %h",
				$sampled(beat_cnt), $sampled(exp_dim));
		end

	a_done_cycles: assert property (@(posedge clk) disable iff (!rst_n)
		um_done |-> run_cycles != 0)
		else begin
			errors++;
			$display("[ERROR] run_cycles got %h while um_done is high", $sampled(run_cycles));
		end

	// done holds with a frozen count until the next start
	a_done_hold: assert property (@(posedge clk) disable iff (!rst_n)
		um_done && !start |=> um_done && $stable(run_cycles))
		else begin
			errors++;
			$display("um_done dropped or run_cycles moved without a start");
		end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	task automatic note_timeout(input string what);
		timed_out = 1'b1;
		timeouts++;
		$display("timeout while waiting for %s", what);
	endtask

	task automatic wait_grad_ready();
		int cycles;
		cycles = 0;
		while (!grad_ready && !timed_out) begin
			@(negedge clk);
			cycles++;
			if (cycles > READY_LIMIT) note_timeout("grad_ready");
		end
	endtask

	// random beats with gaps, reference updated for each accepted one
	task automatic send_gradients(input int dim, input int total, input int shift);
		int    beats;
		int    cycles;
		int    idx;
		lane_t g_lane;
		lane_t x_lane;
		beats = 0;
		cycles = 0;
		while (beats < total && !timed_out) begin
			@(negedge clk);
			grad_valid = (($random(seed) & 3) != 0);
			for (int l = 0; l < LANES; l++) grad[l] = $random(seed);
			if (grad_valid && grad_ready) begin
				idx = beats % dim;
				for (int l = 0; l < LANES; l++) begin
					g_lane = grad[l];
					x_lane = ref_mem[idx][l];
					x_lane = x_lane - (g_lane >>> shift);
					ref_mem[idx][l] = x_lane;
				end
				beats++;
			end
			cycles++;
			if (cycles > GRAD_LIMIT) note_timeout("gradient beats to be taken");
		end
		@(negedge clk);
		grad_valid = 1'b0;
	endtask

	// bursty almost-full until the run reports done
	task automatic drain_writeback();
		int cycles;
		cycles = 0;
		while (!um_done && !timed_out) begin
			@(negedge clk);
			if (x_data_out_almost_full) begin
				x_data_out_almost_full = (($random(seed) & 1) != 0);
			end else begin
				x_data_out_almost_full = (($random(seed) & 3) == 0);
			end
			cycles++;
			if (cycles > WB_LIMIT) note_timeout("um_done");
		end
		x_data_out_almost_full = 1'b0;
	endtask

	task automatic run_case(input int dim, input int epochs, input int shift);
		if (!timed_out) begin
			exp_dim = dim;
			exp_addr = {$random(seed), $random(seed)};
			exp_len = 32'(dim) * 32'd64;
			// model restarts from zero
			for (int i = 0; i < dim; i++) ref_mem[i] = '0;
			@(negedge clk);
			cfg.addr_model = exp_addr;
			cfg.dimension = DIM_W'(dim);
			cfg.number_of_epochs = EPOCH_W'(epochs);
			cfg.step_shift = SHIFT_W'(shift);
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;
			wait_grad_ready();
			send_gradients(dim, dim * epochs, shift);
			drain_writeback();
			// linger in DONE
			repeat (3) @(negedge clk);
		end
	endtask

	initial begin
		seed = 32'h75d9;
		errors = 0;
		timeouts = 0;
		timed_out = 1'b0;
		start = 1'b0;
		cfg = '0;
		grad_valid = 1'b0;
		grad = '0;
		x_data_out_almost_full = 1'b0;
		for (int i = 0; i < DEPTH; i++) ref_mem[i] = '0;
		rst_n = 1'b0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		// full store first, then a smaller model over stale words
		run_case(16, 3, 3);
		run_case(5, 4, 0);
		repeat (4) @(negedge clk);
		$display("checks complete: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* sgd_bw.f */
hdl/sgd_pkg.sv
hdl/sgd_ctrl_fsm.sv
hdl/sgd_word_counter.sv
hdl/sgd_model_ram.sv
hdl/sgd_x_update.sv
hdl/sgd_x_writeback.sv
hdl/sgd_bw_top.sv
verif/sgd_bw_tb.sv

/* Bender.yml */
package:
  name: sgd_bw

sources:
  - files:
      - hdl/sgd_pkg.sv
      - hdl/sgd_ctrl_fsm.sv
      - hdl/sgd_word_counter.sv
      - hdl/sgd_model_ram.sv
      - hdl/sgd_x_update.sv
      - hdl/sgd_x_writeback.sv
      - hdl/sgd_bw_top.sv
  - target: test
    files:
      - verif/sgd_bw_tb.sv
